// File: logic/fpu_pkg.sv
// float word types, operation codes, register map and constants for the coprocessor
package fpu_pkg;

  // ieee single precision fields
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp_fields_t;

  // host bus sees bytes, arithmetic sees fields
  typedef union packed {
    fp_fields_t      f;
    logic [3:0][7:0] b;
  } fp_word_u;

  typedef enum logic [3:0] {
    op_add     = 4'd0,
    op_sub     = 4'd1,
    op_mul     = 4'd2,
    op_k_pi    = 4'd4,
    op_k_piby2 = 4'd5
  } fpu_op_e;

  // byte addresses seen by the host
  typedef enum logic [3:0] {
    a_b0   = 4'd0,
    a_b1   = 4'd1,
    a_b2   = 4'd2,
    a_b3   = 4'd3,
    b_b0   = 4'd4,
    b_b1   = 4'd5,
    b_b2   = 4'd6,
    b_b3   = 4'd7,
    op_reg = 4'd8,
    res_b0 = 4'd9,
    res_b1 = 4'd10,
    res_b2 = 4'd11,
    res_b3 = 4'd12
  } fpu_addr_e;

  // request into an arithmetic unit
  typedef struct packed {
    logic start;
    logic sub;
  } arith_req_t;

  // answer from an arithmetic unit
  typedef struct packed {
    logic     done;
    fp_word_u word;
  } fp_result_t;

  localparam logic [7:0] exp_bias = 8'd127;

  // mantissa width with the hidden bit
  localparam int mant_w = 24;

  localparam logic [31:0] fp_one     = 32'h3f80_0000;
  localparam logic [31:0] fp_pi      = 32'h4049_0fda;
  localparam logic [31:0] fp_pi_by_2 = 32'h3fc9_0fda;

endpackage

// File: logic/fpu_bus_regs.sv
// host operand, operation and result registers with byte write and read decode
`timescale 1ns/1ps

module fpu_bus_regs (
  input  logic               clk,
  input  logic               arst,
  input  logic [7:0]         databus_in,
  input  fpu_pkg::fpu_addr_e addr,
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  logic               res_load,
  input  fpu_pkg::fp_word_u  res_word,
  output logic [7:0]         databus_out,
  output fpu_pkg::fp_word_u  op_a,
  output fpu_pkg::fp_word_u  op_b,
  output fpu_pkg::fpu_op_e   op_code,
  output logic               op_written
);
  import fpu_pkg::*;

  fp_word_u res_reg;
  logic     wr_en;
  logic     rd_en;

  // bus strobes are active low
  assign wr_en = !cs && !wr;
  assign rd_en = !cs && !rd;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      op_a       <= fp_one;
      op_b       <= fp_one;
      op_code    <= op_add;
      op_written <= 1'b0;
      res_reg    <= '0;
    end else begin
      op_written <= 1'b0;
      if (wr_en) begin
        case (addr)
          a_b0, a_b1, a_b2, a_b3: op_a.b[addr[1:0]] <= databus_in;
          b_b0, b_b1, b_b2, b_b3: op_b.b[addr[1:0]] <= databus_in;
          op_reg: begin
            // any code is kept, undefined ones give +0 later
            op_code    <= fpu_op_e'(databus_in[3:0]);
            op_written <= 1'b1;
          end
          default: op_written <= 1'b0;
        endcase
      end
      // result also lands in A for chaining
      if (res_load) begin
        res_reg <= res_word;
        op_a    <= res_word;
      end
    end
  end

  // read mux
  always_comb begin
    databus_out = 8'h00;
    if (rd_en) begin
      case (addr)
        a_b0, a_b1, a_b2, a_b3: databus_out = op_a.b[addr[1:0]];
        b_b0, b_b1, b_b2, b_b3: databus_out = op_b.b[addr[1:0]];
        op_reg:                 databus_out = {4'h0, op_code};
        res_b0:                 databus_out = res_reg.b[0];
        res_b1:                 databus_out = res_reg.b[1];
        res_b2:                 databus_out = res_reg.b[2];
        res_b3:                 databus_out = res_reg.b[3];
        default:                databus_out = 8'h00;
      endcase
    end
  end

endmodule

// File: logic/fpu_host_ctrl.sv
// host handshake state machine driving busy, cmd_end and the start level
`timescale 1ns/1ps

module fpu_host_ctrl (
  input  logic clk,
  input  logic arst,
  input  logic op_written,
  input  logic op_done,
  input  logic end_ack,
  output logic start,
  output logic busy,
  output logic cmd_end
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_finish,
    st_wait_ack
  } state_e;

  state_e state;
  state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (op_written) begin
          state_nxt = st_wait;
        end
      end
      st_wait: begin
        if (op_done) begin
          state_nxt = st_finish;
        end
      end
      // sequencer drops op_done once start is gone
      st_finish: begin
        if (!op_done) begin
          state_nxt = st_wait_ack;
        end
      end
      st_wait_ack: begin
        if (end_ack) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state   <= st_idle;
      start   <= 1'b0;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      state   <= state_nxt;
      // outputs follow the state being entered
      start   <= (state_nxt == st_wait);
      busy    <= (state_nxt != st_idle);
      cmd_end <= (state_nxt == st_wait_ack);
    end
  end

  // host sees end of command only while still marked busy
  a_cmd_end_busy: assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy);

endmodule

// File: logic/fpu_op_ctrl.sv
// operation sequencer dispatching to the arithmetic units and picking the result word
`timescale 1ns/1ps

module fpu_op_ctrl (
  input  logic                clk,
  input  logic                arst,
  input  logic                start,
  input  fpu_pkg::fpu_op_e    op_code,
  input  fpu_pkg::fp_result_t add_res,
  input  fpu_pkg::fp_result_t mul_res,
  output logic                op_done,
  output fpu_pkg::arith_req_t add_req,
  output fpu_pkg::arith_req_t mul_req,
  output logic                res_load,
  output fpu_pkg::fp_word_u   res_word
);
  import fpu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait,
    st_hold
  } state_e;

  state_e   state;
  state_e   state_nxt;
  logic     unit_done;
  logic     load_now;
  fp_word_u unit_word;

  // result source per operation
  always_comb begin
    unit_done = 1'b1;
    unit_word = '0;
    case (op_code)
      op_add, op_sub: begin
        unit_done = add_res.done;
        unit_word = add_res.word;
      end
      op_mul: begin
        unit_done = mul_res.done;
        unit_word = mul_res.word;
      end
      op_k_pi:    unit_word = fp_pi;
      op_k_piby2: unit_word = fp_pi_by_2;
      default:    unit_word = '0;
    endcase
  end

  // unit start only during the issue cycle
  assign add_req.start = (state == st_issue) && (op_code == op_add || op_code == op_sub);
  assign add_req.sub   = (op_code == op_sub);
  assign mul_req.start = (state == st_issue) && (op_code == op_mul);
  assign mul_req.sub   = 1'b0;

  assign load_now = (state == st_issue || state == st_wait) && unit_done;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_issue;
        end
      end
      // adder and constants answer here, multiplier later
      st_issue: state_nxt = unit_done ? st_hold : st_wait;
      st_wait: begin
        if (unit_done) begin
          state_nxt = st_hold;
        end
      end
      st_hold: begin
        if (!start) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state    <= st_idle;
      op_done  <= 1'b0;
      res_load <= 1'b0;
    end else begin
      state    <= state_nxt;
      op_done  <= (state_nxt == st_hold);
      res_load <= load_now;
    end
  end

  always_ff @(posedge clk) begin
    if (load_now) begin
      res_word <= unit_word;
    end
  end

  a_res_load_pulse: assert property (@(posedge clk) disable iff (arst) res_load |=> !res_load);

endmodule

// File: logic/fpu_add_sub.sv
// combinational float add and subtract with alignment, signed sum and normalization
`timescale 1ns/1ps

module fpu_add_sub (
  input  fpu_pkg::arith_req_t add_req,
  input  fpu_pkg::fp_word_u   op_a,
  input  fpu_pkg::fp_word_u   op_b,
  output fpu_pkg::fp_result_t add_res
);
  import fpu_pkg::*;

  logic        a_zero;
  logic        b_zero;
  logic [25:0] mant_a;
  logic [25:0] mant_b;
  logic [25:0] al_a;
  logic [25:0] al_b;
  logic [7:0]  exp_big;
  logic [25:0] sx_a;
  logic [25:0] sx_b;
  logic [25:0] sum;
  logic        sum_neg;
  logic [25:0] mag;
  logic [31:0] norm;
  logic [4:0]  lz;
  logic [9:0]  exp_res;
  fp_word_u    word;

  // exponent field 0 is zero, two spare bits on top for carry and sign
  assign a_zero = (op_a.f.exp == 8'd0);
  assign b_zero = (op_b.f.exp == 8'd0);
  assign mant_a = a_zero ? 26'd0 : {2'b00, 1'b1, op_a.f.frac};
  assign mant_b = b_zero ? 26'd0 : {2'b00, 1'b1, op_b.f.frac};

  // shift the smaller one right, bits falling off are lost
  always_comb begin
    al_a = mant_a;
    al_b = mant_b;
    if (op_a.f.exp < op_b.f.exp) begin
      exp_big = op_b.f.exp;
      if (!a_zero) begin
        al_a = mant_a >> (op_b.f.exp - op_a.f.exp);
      end
    end else begin
      exp_big = op_a.f.exp;
      if (!b_zero) begin
        al_b = mant_b >> (op_a.f.exp - op_b.f.exp);
      end
    end
  end

  // two's complement sum
  assign sx_a    = op_a.f.sign ? -al_a : al_a;
  assign sx_b    = op_b.f.sign ? -al_b : al_b;
  assign sum     = add_req.sub ? sx_a - sx_b : sx_a + sx_b;
  assign sum_neg = sum[25];
  assign mag     = sum_neg ? -sum : sum;

  // leading one search, binary steps instead of a shift loop
  always_comb begin
    norm = {mag, 6'd0};
    lz   = '0;
    if (norm[31:16] == '0) begin
      norm  = norm << 16;
      lz[4] = 1'b1;
    end
    if (norm[31:24] == '0) begin
      norm  = norm << 8;
      lz[3] = 1'b1;
    end
    if (norm[31:28] == '0) begin
      norm  = norm << 4;
      lz[2] = 1'b1;
    end
    if (norm[31:30] == '0) begin
      norm  = norm << 2;
      lz[1] = 1'b1;
    end
    if (!norm[31]) begin
      norm  = norm << 1;
      lz[0] = 1'b1;
    end
  end

  // leading one at mag bit 23 leaves the exponent as is
  assign exp_res = {2'b00, exp_big} + 10'd2 - {5'd0, lz};

  always_comb begin
    word = '0;
    if (mag != '0) begin
      word.f.sign = sum_neg;
      word.f.exp  = exp_res[7:0];
      word.f.frac = norm[30:8];
    end
  end

  assign add_res = {add_req.start, word};

endmodule

// File: logic/fpu_mul.sv
// iterative shift and add float multiplier with exponent and sign handling
`timescale 1ns/1ps

module fpu_mul (
  input  logic                clk,
  input  logic                arst,
  input  fpu_pkg::arith_req_t mul_req,
  input  fpu_pkg::fp_word_u   op_a,
  input  fpu_pkg::fp_word_u   op_b,
  output fpu_pkg::fp_result_t mul_res
);
  import fpu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_add,
    st_shift,
    st_set
  } state_e;

  state_e            state;
  logic [4:0]        step;
  logic              done_q;
  logic [mant_w-1:0] mcand;
  // upper part collects the product, multiplier shifts out below
  logic [2*mant_w:0] prod;
  fp_word_u          res_q;
  fp_word_u          prod_word;
  logic              prod_msb;
  logic [9:0]        exp_sum;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state  <= st_idle;
      step   <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        st_idle: begin
          if (mul_req.start) begin
            state <= st_add;
            step  <= '0;
          end
        end
        st_add: begin
          state <= st_shift;
          step  <= step + 5'd1;
        end
        st_shift: state <= (step == 5'(mant_w)) ? st_set : st_add;
        st_set: begin
          state  <= st_idle;
          done_q <= 1'b1;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (mul_req.start) begin
          mcand <= {1'b1, op_a.f.frac};
          prod  <= {{(mant_w + 1){1'b0}}, 1'b1, op_b.f.frac};
        end
      end
      st_add: begin
        if (prod[0]) begin
          prod[2*mant_w:mant_w] <= prod[2*mant_w:mant_w] + {1'b0, mcand};
        end
      end
      st_shift: prod <= prod >> 1;
      st_set:   res_q <= prod_word;
      default:  res_q <= prod_word;
    endcase
  end

  // product is in [1,4), bit 47 set means one extra exponent step
  assign prod_msb = prod[2*mant_w-1];
  assign exp_sum  = {2'b00, op_a.f.exp} + {2'b00, op_b.f.exp} - {2'b00, exp_bias}
                  + {9'd0, prod_msb};

  always_comb begin
    prod_word = '0;
    if (op_a.f.exp != 8'd0 && op_b.f.exp != 8'd0) begin
      prod_word.f.sign = op_a.f.sign ^ op_b.f.sign;
      prod_word.f.exp  = exp_sum[7:0];
      // truncate below the leading one
      prod_word.f.frac = prod_msb ? prod[2*mant_w-2 -: mant_w-1] : prod[2*mant_w-3 -: mant_w-1];
    end
  end

  assign mul_res = {done_q, res_q};

  a_step_range: assert property (@(posedge clk) disable iff (arst) step <= 5'(mant_w));

endmodule

// File: logic/fpu_top.sv
// coprocessor top level connecting registers, controllers and arithmetic units
`timescale 1ns/1ps

module fpu_top (
  input  logic               clk,
  input  logic               arst,
  input  logic [7:0]         databus_in,
  output logic [7:0]         databus_out,
  input  fpu_pkg::fpu_addr_e addr,
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  logic               end_ack,
  output logic               cmd_end,
  output logic               busy
);
  import fpu_pkg::*;

  fp_word_u   op_a;
  fp_word_u   op_b;
  fp_word_u   res_word;
  fpu_op_e    op_code;
  logic       op_written;
  logic       start;
  logic       op_done;
  logic       res_load;
  arith_req_t add_req;
  arith_req_t mul_req;
  fp_result_t add_res;
  fp_result_t mul_res;

  fpu_bus_regs u_bus_regs (
    .clk         (clk),
    .arst        (arst),
    .databus_in  (databus_in),
    .addr        (addr),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .res_load    (res_load),
    .res_word    (res_word),
    .databus_out (databus_out),
    .op_a        (op_a),
    .op_b        (op_b),
    .op_code     (op_code),
    .op_written  (op_written)
  );

  fpu_host_ctrl u_host_ctrl (
    .clk        (clk),
    .arst       (arst),
    .op_written (op_written),
    .op_done    (op_done),
    .end_ack    (end_ack),
    .start      (start),
    .busy       (busy),
    .cmd_end    (cmd_end)
  );

  fpu_op_ctrl u_op_ctrl (
    .clk      (clk),
    .arst     (arst),
    .start    (start),
    .op_code  (op_code),
    .add_res  (add_res),
    .mul_res  (mul_res),
    .op_done  (op_done),
    .add_req  (add_req),
    .mul_req  (mul_req),
    .res_load (res_load),
    .res_word (res_word)
  );

  fpu_add_sub u_add_sub (
    .add_req (add_req),
    .op_a    (op_a),
    .op_b    (op_b),
    .add_res (add_res)
  );

  fpu_mul u_mul (
    .clk     (clk),
    .arst    (arst),
    .mul_req (mul_req),
    .op_a    (op_a),
    .op_b    (op_b),
    .mul_res (mul_res)
  );

endmodule

// File: bench/fpu_clk_gen.sv
// testbench clock and power-on reset source
`timescale 1ns/1ps

module fpu_clk_gen #(
  parameter int half_period_ns = 10,
  parameter int reset_cycles   = 5
) (
  output logic clk,
  output logic arst
);

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  // reset held for a few full cycles
  initial begin
    arst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    arst <= 1'b0;
  end

endmodule

// File: bench/fpu_tb.sv
// testbench with bus tasks, reference model, random stimulus, compare tasks and timeout
`timescale 1ns/1ps

module fpu_tb;
  import fpu_pkg::*;

  localparam int n_addsub = 40;
  localparam int n_mul    = 20;
  localparam int n_chain  = 8;
  // random runs plus the fixed cases
  localparam int n_ops       = n_addsub + n_mul + n_chain + 10;
  localparam int cycle_limit = 80 * n_ops + 1000;

  // ieee single encodings of 1.0, pi and pi/2
  localparam logic [31:0] one_word     = 32'h3f80_0000;
  localparam logic [31:0] pi_word      = 32'h4049_0fda;
  localparam logic [31:0] half_pi_word = 32'h3fc9_0fda;

  logic       clk;
  logic       arst;
  logic [7:0] databus_in;
  logic [7:0] databus_out;
  fpu_addr_e  addr;
  logic       cs;
  logic       rd;
  logic       wr;
  logic       end_ack;
  logic       cmd_end;
  logic       busy;

  logic [31:0] rng_state;
  fp_word_u    model_a;
  fp_word_u    model_b;
  int          cycles = 0;

  // results waiting for the compare process
  string    name_q[$];
  fp_word_u exp_q[$];
  fp_word_u act_q[$];

  fpu_clk_gen #(
    .half_period_ns (10),
    .reset_cycles   (5)
  ) u_clk_gen (
    .clk  (clk),
    .arst (arst)
  );

  fpu_top uut (
    .clk         (clk),
    .arst        (arst),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .addr        (addr),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .end_ack     (end_ack),
    .cmd_end     (cmd_end),
    .busy        (busy)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // exponent kept in 100..154 so no result leaves the normal range
  function automatic fp_word_u rand_operand();
    logic [31:0] r;
    logic [31:0] r2;
    fp_word_u    w;
    r  = next_rand();
    r2 = next_rand();
    w.f.sign = r[31];
    w.f.exp  = 8'd100 + (r[30:23] % 8'd55);
    w.f.frac = r2[31:9];
    return w;
  endfunction

  function automatic fp_word_u ref_add(input fp_word_u a, input fp_word_u b, input logic sub);
    int       ea;
    int       eb;
    int       ma;
    int       mb;
    int       e;
    int       s;
    int       mag;
    int       p;
    int       frac;
    int       i;
    logic     sb;
    fp_word_u r;
    ea = int'(a.f.exp);
    eb = int'(b.f.exp);
    ma = (ea == 0) ? 0 : int'({1'b1, a.f.frac});
    mb = (eb == 0) ? 0 : int'({1'b1, b.f.frac});
    sb = b.f.sign ^ sub;
    // truncating alignment to the larger exponent
    if (ea < eb) begin
      e  = eb;
      ma = ma >> (eb - ea);
    end else begin
      e  = ea;
      mb = mb >> (ea - eb);
    end
    s = (a.f.sign ? -ma : ma) + (sb ? -mb : mb);
    r = '0;
    if (s != 0) begin
      mag = (s < 0) ? -s : s;
      p   = 0;
      for (i = 0; i < 26; i++) begin
        if (mag[i]) begin
          p = i;
        end
      end
      frac = (p >= 23) ? (mag >> (p - 23)) : (mag << (23 - p));
      e    = e + p - 23;
      r.f.sign = (s < 0);
      r.f.exp  = e[7:0];
      r.f.frac = frac[22:0];
    end
    return r;
  endfunction

  function automatic fp_word_u ref_mul(input fp_word_u a, input fp_word_u b);
    logic [47:0] prod;
    int          e;
    fp_word_u    r;
    r = '0;
    if (a.f.exp != 8'd0 && b.f.exp != 8'd0) begin
      prod = {24'd0, 1'b1, a.f.frac} * {24'd0, 1'b1, b.f.frac};
      e    = int'(a.f.exp) + int'(b.f.exp) - 127 + (prod[47] ? 1 : 0);
      r.f.sign = a.f.sign ^ b.f.sign;
      r.f.exp  = e[7:0];
      r.f.frac = prod[47] ? prod[46:24] : prod[45:23];
    end
    return r;
  endfunction

  function automatic fp_word_u ref_result(input fpu_op_e op, input fp_word_u a,
                                          input fp_word_u b);
    fp_word_u r;
    case (op)
      op_add:     r = ref_add(a, b, 1'b0);
      op_sub:     r = ref_add(a, b, 1'b1);
      op_mul:     r = ref_mul(a, b);
      op_k_pi:    r = pi_word;
      op_k_piby2: r = half_pi_word;
      default:    r = '0;
    endcase
    return r;
  endfunction

  task automatic fail_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input fp_word_u exp_w, input fp_word_u act_w);
    if (act_w !== exp_w) begin
      $display("MISMATCH %s expected %h actual %h", name, exp_w, act_w);
      fail_run();
    end
  endtask

  task automatic check_op(input string name, input fpu_op_e exp_op, input fpu_op_e act_op);
    if (act_op !== exp_op) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp_op, act_op);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp_f, input logic act_f);
    if (act_f !== exp_f) begin
      $display("MISMATCH %s expected %b actual %b", name, exp_f, act_f);
      fail_run();
    end
  endtask

  task automatic expect_word(input string name, input fp_word_u exp_w, input fp_word_u act_w);
    name_q.push_back(name);
    exp_q.push_back(exp_w);
    act_q.push_back(act_w);
  endtask

  task automatic bus_write(input fpu_addr_e a, input logic [7:0] d);
    @(posedge clk);
    addr       <= a;
    databus_in <= d;
    cs         <= 1'b0;
    wr         <= 1'b0;
    @(posedge clk);
    cs <= 1'b1;
    wr <= 1'b1;
  endtask

  task automatic bus_read(input fpu_addr_e a, output logic [7:0] d);
    @(posedge clk);
    addr <= a;
    cs   <= 1'b0;
    rd   <= 1'b0;
    @(negedge clk);
    d = databus_out;
    @(posedge clk);
    cs <= 1'b1;
    rd <= 1'b1;
  endtask

  task automatic write_word(input fpu_addr_e base, input fp_word_u w);
    int i;
    for (i = 0; i < 4; i++) begin
      bus_write(fpu_addr_e'(4'(base) + 4'(i)), w.b[i]);
    end
  endtask

  task automatic read_word(input fpu_addr_e base, output fp_word_u w);
    logic [7:0] d;
    int         i;
    w = '0;
    for (i = 0; i < 4; i++) begin
      bus_read(fpu_addr_e'(4'(base) + 4'(i)), d);
      w.b[i] = d;
    end
  endtask

  task automatic wait_reset_release();
    @(negedge clk);
    while (arst) begin
      @(negedge clk);
    end
  endtask

  // once busy has risen it must stay up until cmd_end
  task automatic wait_cmd_end(input string name);
    logic seen_busy;
    seen_busy = 1'b0;
    @(negedge clk);
    while (!cmd_end) begin
      if (seen_busy) begin
        check_flag({name, " busy held"}, 1'b1, busy);
      end
      seen_busy = seen_busy | busy;
      @(negedge clk);
    end
  endtask

  task automatic pulse_ack();
    @(posedge clk);
    end_ack <= 1'b1;
    @(posedge clk);
    end_ack <= 1'b0;
  endtask

  task automatic run_op(input string name, input fpu_op_e op, input int ack_delay);
    fp_word_u expect_w;
    fp_word_u got;
    logic [7:0] d;
    expect_w = ref_result(op, model_a, model_b);
    bus_write(op_reg, {4'h0, op});
    wait_cmd_end(name);
    check_flag({name, " busy at cmd_end"}, 1'b1, busy);
    read_word(res_b0, got);
    expect_word(name, expect_w, got);
    // host holds off the acknowledge for a while
    repeat (ack_delay) begin
      @(negedge clk);
      check_flag({name, " cmd_end held"}, 1'b1, cmd_end);
      check_flag({name, " busy before ack"}, 1'b1, busy);
    end
    pulse_ack();
    @(negedge clk);
    check_flag({name, " busy after ack"}, 1'b0, busy);
    check_flag({name, " cmd_end after ack"}, 1'b0, cmd_end);
    bus_read(op_reg, d);
    check_op({name, " op readback"}, op, fpu_op_e'(d[3:0]));
    model_a = expect_w;
  endtask

  // compare process
  always @(posedge clk) begin
    while (act_q.size() > 0) begin
      check_word(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the DUT never finished its operations", cycles);
      fail_run();
    end
  end

  initial begin
    fp_word_u    w;
    logic [31:0] r;
    logic [7:0]  d;
    int          i;
    databus_in = 8'h00;
    addr       = a_b0;
    cs         = 1'b1;
    rd         = 1'b1;
    wr         = 1'b1;
    end_ack    = 1'b0;
    rng_state  = 32'hbc43_b5d9;
    model_a    = one_word;
    model_b    = one_word;
    wait_reset_release();

    // reset state
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset cmd_end", 1'b0, cmd_end);
    read_word(a_b0, w);
    expect_word("reset A", one_word, w);
    read_word(b_b0, w);
    expect_word("reset B", one_word, w);
    bus_read(op_reg, d);
    check_op("reset op", op_add, fpu_op_e'(d[3:0]));
    read_word(res_b0, w);
    expect_word("reset result", '0, w);

    // operand readback
    model_a = rand_operand();
    model_b = rand_operand();
    write_word(a_b0, model_a);
    write_word(b_b0, model_b);
    read_word(a_b0, w);
    expect_word("readback A", model_a, w);
    read_word(b_b0, w);
    expect_word("readback B", model_b, w);

    for (i = 0; i < n_addsub; i++) begin
      model_a = rand_operand();
      model_b = rand_operand();
      write_word(a_b0, model_a);
      write_word(b_b0, model_b);
      r = next_rand();
      run_op($sformatf("add_sub %0d", i), r[31] ? op_sub : op_add, 0);
    end

    // cancellation and zero operands
    model_a = rand_operand();
    model_b = model_a;
    model_b.f.sign = ~model_a.f.sign;
    write_word(a_b0, model_a);
    write_word(b_b0, model_b);
    run_op("cancel add", op_add, 0);
    model_a = rand_operand();
    model_b = model_a;
    write_word(a_b0, model_a);
    write_word(b_b0, model_b);
    run_op("cancel sub", op_sub, 0);
    model_a = '0;
    model_b = rand_operand();
    write_word(a_b0, model_a);
    write_word(b_b0, model_b);
    run_op("zero A add", op_add, 0);
    model_a = rand_operand();
    model_b = 32'h8000_0000;
    write_word(a_b0, model_a);
    write_word(b_b0, model_b);
    run_op("zero B sub", op_sub, 1);

    for (i = 0; i < n_mul; i++) begin
      model_a = rand_operand();
      model_b = rand_operand();
      write_word(a_b0, model_a);
      write_word(b_b0, model_b);
      r = next_rand();
      run_op($sformatf("mul %0d", i), op_mul, int'(r[31:30]));
    end
    model_a = '0;
    model_b = rand_operand();
    write_word(a_b0, model_a);
    write_word(b_b0, model_b);
    run_op("zero A mul", op_mul, 2);
    model_a = rand_operand();
    model_b = '0;
    write_word(a_b0, model_a);
    write_word(b_b0, model_b);
    run_op("zero B mul", op_mul, 0);

    run_op("load pi", op_k_pi, 0);
    run_op("load pi/2", op_k_piby2, 0);
    run_op("undefined op", fpu_op_e'(4'd3), 0);

    // chained results feed operand A
    model_a = rand_operand();
    model_b = rand_operand();
    write_word(a_b0, model_a);
    write_word(b_b0, model_b);
    run_op("chain start", op_add, 0);
    for (i = 0; i < n_chain; i++) begin
      read_word(a_b0, w);
      expect_word($sformatf("chain A %0d", i), model_a, w);
      model_b = rand_operand();
      write_word(b_b0, model_b);
      run_op($sformatf("chain sub %0d", i), op_sub, 0);
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    if (act_q.size() != 0) begin
      $display("results were left uncompared at the end of the run");
      fail_run();
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// File: flist.f
logic/fpu_pkg.sv
logic/fpu_bus_regs.sv
logic/fpu_host_ctrl.sv
logic/fpu_op_ctrl.sv
logic/fpu_add_sub.sv
logic/fpu_mul.sv
logic/fpu_top.sv
bench/fpu_clk_gen.sv
bench/fpu_tb.sv

// File: Makefile
# Verilator flow for the floating-point coprocessor
# any of these can be set on the command line, e.g. make sim JOBS=8

VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= fpu_tb
LINT_TOP  ?= fpu_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 4

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(LINT_TOP)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)
